// ==== files.f ====
+incdir+hw
hw/rhythm_pkg.sv
hw/chart_regs.sv
hw/play_sequencer.sv
hw/score_keeper.sv
hw/rhythm_top.sv
verif/rhythm_assert.sv
verif/rhythm_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module rhythm_tb -f files.f -o rhythm_sim

out=$(./obj_dir/rhythm_sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== verif/rhythm_tb.sv ====
`timescale 1ns/10ps
`include "rhythm_macros.svh"

module rhythm_tb;

    localparam int N_NOTES  = 8;
    localparam int CD_CYC   = 4 * `COUNT_TICKS;
    localparam int RUN_CYC  = CD_CYC + N_NOTES * `NOTE_TICKS;
    localparam int SCANS    = N_NOTES * (`NOTE_TICKS / `SCAN_TICKS);
    // Worst case AXI transfer with the ready held back
    localparam int XFER_CYC = 8;
    localparam int N_XFER   = 2 * N_NOTES + 16;
    localparam int LIMIT    = 4 + 3 * RUN_CYC + N_XFER * XFER_CYC + 200;

    logic                   prog_clk;
    logic                   rst;
    logic [`AXI_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [31:0]            rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    rhythm_pkg::note_t      play_keys;
    rhythm_pkg::note_t      play_note;
    logic [7:0]             led;
    logic                   playing;
    logic                   done;

    logic [31:0]       lfsr = 32'h76369464;
    int                cyc = 0;
    int                err_cnt = 0;
    int                wr_cyc;
    rhythm_pkg::note_t chart [N_NOTES];

    rhythm_top u_dut (.*);

    initial begin
        prog_clk = 1'b0;
        forever #50 prog_clk = ~prog_clk;
    end

    always @(posedge prog_clk) cyc <= cyc + 1;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // One key, at most one octave bit
    function automatic rhythm_pkg::note_t random_note();
        rhythm_pkg::note_t n;
        logic [31:0]       key;
        logic [31:0]       oct;
        key = rand_bits(3) % 7;
        oct = rand_bits(2);
        n = '0;
        n[key[2:0]] = 1'b1;
        if (oct == 32'd1) begin
            n[`KEY_W] = 1'b1;
        end else if (oct == 32'd2) begin
            n[`KEY_W+1] = 1'b1;
        end
        return n;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act == exp) else begin
            err_cnt++;
            $display("ERR %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic write_reg(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        int hold;
        hold = int'(rand_bits(2));
        @(posedge prog_clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= (hold == 0);
        do @(negedge prog_clk); while (!(awready && wready));
        @(posedge prog_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // First cycle after the handshake, where start_pulse sits
        @(negedge prog_clk);
        wr_cyc = cyc;
        repeat (hold) @(negedge prog_clk);
        @(posedge prog_clk);
        bready <= 1'b1;
        do @(negedge prog_clk); while (bvalid);
    endtask

    task automatic read_reg(input logic [`AXI_ADDR_W-1:0] addr, output logic [31:0] data);
        int hold;
        hold = int'(rand_bits(2));
        @(posedge prog_clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= (hold == 0);
        do @(negedge prog_clk); while (!arready);
        @(posedge prog_clk);
        arvalid <= 1'b0;
        @(negedge prog_clk);
        data = rdata;
        repeat (hold) @(negedge prog_clk);
        @(posedge prog_clk);
        rready <= 1'b1;
        do @(negedge prog_clk); while (rvalid);
    endtask

    task automatic start_run(input logic [31:0] ctrl, input string name);
        write_reg(`REG_CTRL, ctrl);
        do @(negedge prog_clk); while (!playing);
        check_val(name, 32'(CD_CYC), 32'(cyc - wr_cyc));
    endtask

    // Walks the slots from the cycle playing rose, keys optionally following the chart
    task automatic play_slots(input logic use_keys, input string name);
        for (int k = 0; k < N_NOTES; k++) begin
            for (int t = 0; t < `NOTE_TICKS; t++) begin
                @(posedge prog_clk);
                if (use_keys && (t == `NOTE_TICKS - 1) && (k < N_NOTES - 1)) begin
                    play_keys <= chart[k+1];
                end
                @(negedge prog_clk);
                check_val({name, " note"}, 32'(chart[k]), 32'(play_note));
                check_val({name, " done"},
                          32'((k == N_NOTES - 1) && (t == `NOTE_TICKS - 1)), 32'(done));
            end
        end
    endtask

    initial begin
        while (cyc < LIMIT) @(posedge prog_clk);
        $display("Timeout after %0d cycles, the test sequence did not finish", LIMIT);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        int          play_cyc;
        int          fails;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        play_keys = '0;
        repeat (4) @(posedge prog_clk);
        rst <= 1'b0;

        read_reg(`REG_STATUS, rd);
        check_val("reset status", 32'd0, rd);

        // Chart load and read back
        for (int k = 0; k < N_NOTES; k++) begin
            chart[k] = random_note();
            write_reg(`CHART_BASE + 9'(4 * k), 32'(chart[k]));
        end
        write_reg(`REG_COUNT, 32'(N_NOTES));
        for (int k = 0; k < N_NOTES; k++) begin
            read_reg(`CHART_BASE + 9'(4 * k), rd);
            check_val("chart readback", 32'(chart[k]), rd);
        end
        read_reg(`REG_COUNT, rd);
        check_val("count readback", 32'(N_NOTES), rd);

        // Auto play
        start_run(32'h3, "auto countdown");
        play_slots(1'b0, "auto");
        read_reg(`REG_SCORE, rd);
        check_val("auto score", 32'(`PTS_AUTO * SCANS), 32'(rd[13:0]));
        check_val("auto max score", 32'(`PTS_HIT * SCANS), 32'(rd[29:16]));

        // Manual play, keys on every note
        @(posedge prog_clk);
        play_keys <= chart[0];
        start_run(32'h1, "match countdown");
        play_slots(1'b1, "match");
        @(posedge prog_clk);
        play_keys <= '0;
        read_reg(`REG_SCORE, rd);
        check_val("match score", 32'(`PTS_HIT * SCANS), 32'(rd[13:0]));
        check_val("match max score", 32'(`PTS_HIT * SCANS), 32'(rd[29:16]));

        // Manual play with idle keys and a second start mid-run
        start_run(32'h1, "idle countdown");
        play_cyc = cyc;
        write_reg(`REG_CTRL, 32'h1);
        do @(negedge prog_clk); while (!done);
        check_val("restart ignored", 32'(N_NOTES * `NOTE_TICKS), 32'(cyc - play_cyc));
        read_reg(`REG_SCORE, rd);
        check_val("idle score", 32'd0, 32'(rd[13:0]));
        check_val("idle max score", 32'(`PTS_HIT * SCANS), 32'(rd[29:16]));
        read_reg(`REG_STATUS, rd);
        check_val("final state", 32'd3, 32'(rd[1:0]));

        fails = u_dut.u_assert.fail_cnt;
        $display("Summary: %0d value errors, %0d assertion failures", err_cnt, fails);
        if ((err_cnt == 0) && (fails == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verif/rhythm_assert.sv ====
`timescale 1ns/10ps
`include "rhythm_macros.svh"

module rhythm_assert (
    input logic                prog_clk,
    input logic                rst,
    input logic                awready,
    input logic                wready,
    input logic                arready,
    input logic                bvalid,
    input logic                bready,
    input logic [1:0]          bresp,
    input logic                rvalid,
    input logic                rready,
    input logic [1:0]          rresp,
    input logic [31:0]         rdata,
    input logic                playing,
    input logic                done,
    input logic                auto_play,
    input logic [`NOTE_W-1:0]  play_note,
    input logic [7:0]          led
);

    int reset_fails = 0;
    int bhold_fails = 0;
    int rhold_fails = 0;
    int resp_fails  = 0;
    int led_fails   = 0;
    int fail_cnt;

    // Key field in LED order, C on the top LED
    logic [`KEY_W-1:0] key_rev;

    always_comb begin
        for (int i = 0; i < `KEY_W; i++) begin
            key_rev[`KEY_W-1-i] = play_note[i];
        end
    end

    assign fail_cnt = reset_fails + bhold_fails + rhold_fails + resp_fails + led_fails;

    a_reset: assert property (@(posedge prog_clk) rst |->
        (!playing && !done && !bvalid && !rvalid && (led == '0) && awready && wready && arready))
    else begin
        $error("outputs not idle while reset is held");
        reset_fails++;
    end

    // Write response waits for bready
    a_bhold: assert property (@(posedge prog_clk) disable iff (rst)
        (bvalid && !bready) |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        bhold_fails++;
    end

    a_rhold: assert property (@(posedge prog_clk) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else begin
        $error("read data not held until rready");
        rhold_fails++;
    end

    a_resp: assert property (@(posedge prog_clk) disable iff (rst)
        (bvalid || rvalid) |-> ((bresp == 2'b00) && (rresp == 2'b00)))
    else begin
        $error("response code is not OKAY");
        resp_fails++;
    end

    // LEDs settle one cycle into the slot
    a_led: assert property (@(posedge prog_clk) disable iff (rst)
        (playing && $past(playing) && auto_play) |->
        ($onehot(led[7:1]) && (led[7:1] == key_rev) &&
         (led[0] == (play_note[`KEY_W] | play_note[`KEY_W+1]))))
    else begin
        $error("LED pattern does not match the sounded note");
        led_fails++;
    end

endmodule

bind rhythm_top rhythm_assert u_assert (
    .prog_clk  (prog_clk),
    .rst       (rst),
    .awready   (awready),
    .wready    (wready),
    .arready   (arready),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rresp     (rresp),
    .rdata     (rdata),
    .playing   (playing),
    .done      (done),
    .auto_play (auto_play),
    .play_note (play_note),
    .led       (led)
);

// ==== hw/rhythm_top.sv ====
`timescale 1ns/10ps
`include "rhythm_macros.svh"

module rhythm_top (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  rhythm_pkg::note_t      play_keys,
    output rhythm_pkg::note_t      play_note,
    output logic [7:0]             led,
    output logic                   playing,
    output logic                   done
);

    logic                    start_pulse;
    logic                    auto_play;
    logic [`IDX_W:0]         note_count;
    rhythm_pkg::note_t       chart_note;
    rhythm_pkg::play_state_e state;
    rhythm_pkg::note_idx_t   cur_idx;
    rhythm_pkg::score_t      score;
    rhythm_pkg::score_t      max_score;

    assign playing = (state == rhythm_pkg::PLAYING);
    assign done    = (state == rhythm_pkg::DONE);

    chart_regs u_regs (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .cur_idx     (cur_idx),
        .state       (state),
        .score       (score),
        .max_score   (max_score),
        .chart_note  (chart_note),
        .note_count  (note_count),
        .auto_play   (auto_play),
        .start_pulse (start_pulse)
    );

    play_sequencer u_seq (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .auto_play   (auto_play),
        .note_count  (note_count),
        .chart_note  (chart_note),
        .play_keys   (play_keys),
        .state       (state),
        .cur_idx     (cur_idx),
        .play_note   (play_note),
        .led         (led)
    );

    score_keeper u_score (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .state       (state),
        .auto_play   (auto_play),
        .chart_note  (chart_note),
        .play_keys   (play_keys),
        .score       (score),
        .max_score   (max_score)
    );

endmodule

// ==== hw/score_keeper.sv ====
`timescale 1ns/10ps
`include "rhythm_macros.svh"

module score_keeper (
    input  logic                    prog_clk,
    input  logic                    rst,
    input  logic                    start_pulse,
    input  rhythm_pkg::play_state_e state,
    input  logic                    auto_play,
    input  rhythm_pkg::note_t       chart_note,
    input  rhythm_pkg::note_t       play_keys,
    output rhythm_pkg::score_t      score,
    output rhythm_pkg::score_t      max_score
);

    localparam int SCAN_W = ($clog2(`SCAN_TICKS) > 0) ? $clog2(`SCAN_TICKS) : 1;

    localparam rhythm_pkg::score_t HIT   = `PTS_HIT;
    localparam rhythm_pkg::score_t LATE1 = `PTS_LATE1;
    localparam rhythm_pkg::score_t LATE2 = `PTS_LATE2;
    localparam rhythm_pkg::score_t AUTO  = `PTS_AUTO;

    logic [SCAN_W-1:0] scan_tick;
    logic              scan;
    logic              note_live;
    logic              key_down;
    rhythm_pkg::note_t hist_prev;
    rhythm_pkg::note_t hist_old;

    assign scan      = (state == rhythm_pkg::PLAYING) && (scan_tick == '0);
    assign note_live = (chart_note[`KEY_W-1:0] != '0);
    assign key_down  = (play_keys[`KEY_W-1:0] != '0);

    // Scan phase restarts on entry into PLAYING
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            scan_tick <= '0;
        end else if (state != rhythm_pkg::PLAYING) begin
            scan_tick <= '0;
        end else if (scan_tick == SCAN_W'(`SCAN_TICKS - 1)) begin
            scan_tick <= '0;
        end else begin
            scan_tick <= scan_tick + 1'b1;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score     <= '0;
            max_score <= '0;
            hist_prev <= '0;
            hist_old  <= '0;
        end else if (start_pulse) begin
            score     <= '0;
            max_score <= '0;
            hist_prev <= '0;
            hist_old  <= '0;
        end else if (scan && note_live) begin
            max_score <= max_score + HIT;
            if (auto_play) begin
                score <= score + AUTO;
            end else if (key_down) begin
                hist_prev <= play_keys;
                hist_old  <= hist_prev;
                // Late matches look at the captures before this scan
                if (play_keys == chart_note) begin
                    score <= score + HIT;
                end else if (hist_prev == chart_note) begin
                    score <= score + LATE1;
                end else if (hist_old == chart_note) begin
                    score <= score + LATE2;
                end
            end
        end
    end

endmodule

// ==== hw/play_sequencer.sv ====
`timescale 1ns/10ps
`include "rhythm_macros.svh"

module play_sequencer (
    input  logic                    prog_clk,
    input  logic                    rst,
    input  logic                    start_pulse,
    input  logic                    auto_play,
    input  logic [`IDX_W:0]         note_count,
    input  rhythm_pkg::note_t       chart_note,
    input  rhythm_pkg::note_t       play_keys,
    output rhythm_pkg::play_state_e state,
    output rhythm_pkg::note_idx_t   cur_idx,
    output rhythm_pkg::note_t       play_note,
    output logic [7:0]              led
);

    // Four countdown steps of COUNT_TICKS each
    localparam int CD_LEN = 4 * `COUNT_TICKS;
    localparam int CD_W   = $clog2(CD_LEN);
    localparam int SLOT_W = ($clog2(`NOTE_TICKS) > 0) ? $clog2(`NOTE_TICKS) : 1;

    logic [CD_W-1:0]   cd_cnt;
    logic [SLOT_W-1:0] slot_tick;
    logic              slot_start;
    logic              last_note;
    logic [`KEY_W-1:0] keys;
    logic [7:0]        led_next;

    assign slot_start = (state == rhythm_pkg::PLAYING) && (slot_tick == '0);
    assign last_note  = (({1'b0, cur_idx} + 1'b1) == note_count);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state     <= rhythm_pkg::IDLE;
            cd_cnt    <= '0;
            slot_tick <= '0;
            cur_idx   <= '0;
        end else begin
            case (state)
                rhythm_pkg::IDLE, rhythm_pkg::DONE: begin
                    if (start_pulse) begin
                        cur_idx   <= '0;
                        slot_tick <= '0;
                        // Start cycle is the first countdown cycle
                        cd_cnt    <= CD_W'(1);
                        if (note_count == '0) begin
                            state <= rhythm_pkg::DONE;
                        end else begin
                            state <= rhythm_pkg::COUNTDOWN;
                        end
                    end
                end
                rhythm_pkg::COUNTDOWN: begin
                    if (cd_cnt == CD_W'(CD_LEN - 1)) begin
                        state <= rhythm_pkg::PLAYING;
                    end else begin
                        cd_cnt <= cd_cnt + 1'b1;
                    end
                end
                rhythm_pkg::PLAYING: begin
                    if (slot_tick == SLOT_W'(`NOTE_TICKS - 1)) begin
                        slot_tick <= '0;
                        if (last_note) begin
                            state <= rhythm_pkg::DONE;
                        end else begin
                            cur_idx <= cur_idx + 1'b1;
                        end
                    end else begin
                        slot_tick <= slot_tick + 1'b1;
                    end
                end
                default: begin
                    state <= rhythm_pkg::IDLE;
                end
            endcase
        end
    end

    // LED pattern for the current chart note
    assign keys = chart_note[`KEY_W-1:0];

    always_comb begin
        led_next[0]   = chart_note[`KEY_W] | chart_note[`KEY_W+1];
        led_next[7:1] = '0;
        if ((keys != '0) && ((keys & (keys - 1'b1)) == '0)) begin
            // C on led[7] down to B on led[1]
            for (int i = 0; i < `KEY_W; i++) begin
                led_next[7-i] = keys[i];
            end
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            play_note <= '0;
            led       <= '0;
        end else if (slot_start) begin
            play_note <= auto_play ? chart_note : play_keys;
            led       <= led_next;
        end
    end

endmodule

// ==== hw/chart_regs.sv ====
`timescale 1ns/10ps
`include "rhythm_macros.svh"

module chart_regs (
    input  logic                    prog_clk,
    input  logic                    rst,
    input  logic [`AXI_ADDR_W-1:0]  awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXI_ADDR_W-1:0]  araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  rhythm_pkg::note_idx_t   cur_idx,
    input  rhythm_pkg::play_state_e state,
    input  rhythm_pkg::score_t      score,
    input  rhythm_pkg::score_t      max_score,
    output rhythm_pkg::note_t       chart_note,
    output logic [`IDX_W:0]         note_count,
    output logic                    auto_play,
    output logic                    start_pulse
);

    localparam int CNT_W = `IDX_W + 1;

    rhythm_pkg::note_t chart_mem [`CHART_LEN];

    logic        wr_hs;
    logic        rd_hs;
    logic        run_idle;
    logic [31:0] rd_word;

    // Chart window starts at CHART_BASE, one word per entry
    function automatic logic in_chart(input logic [`AXI_ADDR_W-1:0] addr);
        logic [`AXI_ADDR_W-1:0] base;
        base = `CHART_BASE;
        return addr[`AXI_ADDR_W-1:`IDX_W+2] == base[`AXI_ADDR_W-1:`IDX_W+2];
    endfunction

    // Address and data taken together, only with no response pending
    assign awready = ~bvalid;
    assign wready  = ~bvalid;
    // Full-word writes only
    assign wr_hs   = awvalid & wvalid & ~bvalid;

    assign arready = ~rvalid;
    assign rd_hs   = arvalid & ~rvalid;

    // Always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    assign run_idle = (state == rhythm_pkg::IDLE) || (state == rhythm_pkg::DONE);

    assign chart_note = chart_mem[cur_idx];

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            auto_play   <= 1'b0;
            note_count  <= '0;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= 1'b0;

            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            if (wr_hs && (awaddr == `REG_CTRL)) begin
                auto_play   <= wdata[1];
                // Start only counts between runs
                start_pulse <= wdata[0] & run_idle;
            end

            if (wr_hs && (awaddr == `REG_COUNT)) begin
                if (wdata > 32'(`CHART_LEN)) begin
                    note_count <= CNT_W'(`CHART_LEN);
                end else begin
                    note_count <= wdata[`IDX_W:0];
                end
            end
        end
    end

    // Chart storage and read data
    always_ff @(posedge prog_clk) begin
        if (wr_hs && in_chart(awaddr)) begin
            chart_mem[awaddr[`IDX_W+1:2]] <= wdata[`NOTE_W-1:0];
        end
        if (rd_hs) begin
            rdata <= rd_word;
        end
    end

    always_comb begin
        rd_word = '0;
        if (in_chart(araddr)) begin
            rd_word[`NOTE_W-1:0] = chart_mem[araddr[`IDX_W+1:2]];
        end else begin
            case (araddr)
                `REG_CTRL: begin
                    // Start bit reads back as zero
                    rd_word[1] = auto_play;
                end
                `REG_COUNT: begin
                    rd_word[`IDX_W:0] = note_count;
                end
                `REG_STATUS: begin
                    rd_word[1:0]        = state;
                    rd_word[`IDX_W+7:8] = cur_idx;
                end
                `REG_SCORE: begin
                    rd_word[`SCORE_W-1:0]   = score;
                    rd_word[`SCORE_W+15:16] = max_score;
                end
                default: begin
                    rd_word = '0;
                end
            endcase
        end
    end

endmodule

// ==== hw/rhythm_pkg.sv ====
`include "rhythm_macros.svh"

package rhythm_pkg;

    // One-hot key field C..B in the low bits, octave up above it, octave down on top
    typedef logic [`NOTE_W-1:0] note_t;

    typedef logic [`SCORE_W-1:0] score_t;

    // Chart entry index
    typedef logic [`IDX_W-1:0] note_idx_t;

    // Encoding is what REG_STATUS reports
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        COUNTDOWN = 2'd1,
        PLAYING   = 2'd2,
        DONE      = 2'd3
    } play_state_e;

endpackage

// ==== hw/rhythm_macros.svh ====
`ifndef RHYTHM_MACROS_SVH
`define RHYTHM_MACROS_SVH

// Note code layout
`define KEY_W       7
`define NOTE_W      9
`define SCORE_W     14

// Chart size
`define CHART_LEN   32
`define IDX_W       5

// Timing in prog_clk cycles
`define COUNT_TICKS 4
`define NOTE_TICKS  8
// NOTE_TICKS has to be a multiple of SCAN_TICKS
`define SCAN_TICKS  2

// Credit per scan
`define PTS_HIT     5
`define PTS_LATE1   3
`define PTS_LATE2   2
`define PTS_AUTO    4

// Register map
`define AXI_ADDR_W  9
`define REG_CTRL    9'h000
`define REG_COUNT   9'h004
`define REG_STATUS  9'h008
`define REG_SCORE   9'h00C
`define CHART_BASE  9'h100

`endif
